/* verilog/mem_pkg.sv */
// data memory shared types: access width code, data sizes and doubleword views
package mem_pkg;

    // data path width, one doubleword
    localparam int DATA_W = 64;

    // byte lanes per doubleword
    localparam int MASK_W = DATA_W / 8;

    // access size code, shared by the load and store paths
    typedef enum logic [1:0] {
        WIDTH_BYTE   = 2'd0,
        WIDTH_HALF   = 2'd1,
        WIDTH_WORD   = 2'd2,
        WIDTH_DOUBLE = 2'd3
    } mem_width_e;

    // one doubleword seen as lanes of each access size
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
        logic [63:0]      raw;
    } dword_u;

endpackage

/* verilog/mem_wr_if.sv */
// doubleword write bus from the store merger to the RAM array
`timescale 1ns/1ps

interface mem_wr_if #(
    parameter int IDX_W = 10
);
    import mem_pkg::*;

    logic [IDX_W-1:0]  widx;
    dword_u            wdata;
    // one bit per byte lane
    logic [MASK_W-1:0] bmask;
    logic              wen;

    modport source (
        output widx, wdata, bmask, wen
    );

    modport sink (
        input widx, wdata, bmask, wen
    );

endinterface

/* verilog/mem_addr_check.sv */
// address decoder: window and alignment checks plus doubleword index per path
`timescale 1ns/1ps

module mem_addr_check #(
    parameter logic [mem_pkg::DATA_W-1:0] MEM_BASE = 64'h0000_0000_8000_0000,
    parameter int                         IDX_W    = 10
) (
    input  logic [mem_pkg::DATA_W-1:0] raddr,
    input  logic [mem_pkg::DATA_W-1:0] waddr,
    input  mem_pkg::mem_width_e        width,
    output logic [IDX_W-1:0]           ridx,
    output logic                       rfault,
    output logic [IDX_W-1:0]           widx,
    output logic                       wfault
);
    import mem_pkg::*;

    // byte offset bits covering the whole window
    localparam int OFF_W = IDX_W + 3;

    logic [DATA_W-1:0] roff;
    logic [DATA_W-1:0] woff;

    // low address bits must be a multiple of the access size
    function automatic logic misaligned(input logic [2:0] lo, input mem_width_e w);
        logic bad;
        case (w)
            WIDTH_BYTE: bad = 1'b0;
            WIDTH_HALF: bad = lo[0];
            WIDTH_WORD: bad = |lo[1:0];
            default:    bad = |lo;
        endcase
        return bad;
    endfunction

    // an address below the base wraps to a large offset
    function automatic logic outside(input logic [DATA_W-1:0] off);
        return |(off >> OFF_W);
    endfunction

    assign roff = raddr - MEM_BASE;
    assign woff = waddr - MEM_BASE;

    assign ridx = roff[OFF_W-1:3];
    assign widx = woff[OFF_W-1:3];

    assign rfault = outside(roff) | misaligned(raddr[2:0], width);
    assign wfault = outside(woff) | misaligned(waddr[2:0], width);

endmodule

/* verilog/mem_store_merge.sv */
// store merger: byte mask and lane placement of one store doubleword
`timescale 1ns/1ps

module mem_store_merge #(
    parameter int IDX_W = 10
) (
    input  logic [2:0]                 waddr_lo,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    input  mem_pkg::mem_width_e        width,
    input  logic [IDX_W-1:0]           widx,
    input  logic                       wfault,
    input  logic                       wen,
    mem_wr_if.source                   wr
);
    import mem_pkg::*;

    logic [MASK_W-1:0] size_mask;
    dword_u            lane;

    // lane mask before the shift to the addressed byte
    always_comb begin
        case (width)
            WIDTH_BYTE: size_mask = 8'h01;
            WIDTH_HALF: size_mask = 8'h03;
            WIDTH_WORD: size_mask = 8'h0f;
            default:    size_mask = 8'hff;
        endcase
    end

    // copy the store data into every lane of its size, the mask picks one
    always_comb begin
        lane.raw = wdata;
        case (width)
            WIDTH_BYTE: lane.bytes  = {MASK_W{wdata[7:0]}};
            WIDTH_HALF: lane.halves = {4{wdata[15:0]}};
            WIDTH_WORD: lane.words  = {2{wdata[31:0]}};
            default:    lane.raw    = wdata;
        endcase
    end

    assign wr.widx  = widx;
    assign wr.wdata = lane;
    assign wr.bmask = size_mask << waddr_lo;
    // a faulting store never reaches the array
    assign wr.wen   = wen & ~wfault;

endmodule

/* verilog/mem_dword_ram.sv */
// doubleword RAM array with byte-enable writes and a registered read port
`timescale 1ns/1ps

module mem_dword_ram #(
    parameter int IDX_W = 10
) (
    input  logic             clk,
    input  logic             arst_n,
    mem_wr_if.sink           wr,
    input  logic [IDX_W-1:0] ridx,
    input  logic             ren,
    output mem_pkg::dword_u  rword
);
    import mem_pkg::*;

    localparam int DEPTH = 2 ** IDX_W;

    logic [MASK_W-1:0][7:0] mem [DEPTH];

    // byte-enable write at the rising edge
    always_ff @(posedge clk) begin
        if (wr.wen) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (wr.bmask[b]) begin
                    mem[wr.widx][b] <= wr.wdata.bytes[b];
                end
            end
        end
    end

    // read sees the array before a write on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rword <= '0;
        end else if (ren) begin
            rword.bytes <= mem[ridx];
        end
    end

endmodule

/* verilog/mem_load_extract.sv */
// load extractor: lane select and zero extension, plus both fault outputs
`timescale 1ns/1ps

module mem_load_extract (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       ren,
    input  logic [2:0]                 raddr_lo,
    input  mem_pkg::mem_width_e        width,
    input  logic                       rfault,
    input  logic                       wen,
    input  logic                       wfault,
    input  mem_pkg::dword_u            rword,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                       load_fault,
    output logic                       store_fault
);
    import mem_pkg::*;

    logic [2:0]        off_q;
    mem_width_e        width_q;
    logic              fault_q;
    logic [DATA_W-1:0] lane;

    // load controls line up with the ram output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            off_q       <= '0;
            width_q     <= WIDTH_BYTE;
            fault_q     <= 1'b0;
            store_fault <= 1'b0;
        end else begin
            if (ren) begin
                off_q   <= raddr_lo;
                width_q <= width;
                fault_q <= rfault;
            end
            // single cycle pulse per faulting store
            store_fault <= wen & wfault;
        end
    end

    always_comb begin
        case (width_q)
            WIDTH_BYTE: lane = {56'b0, rword.bytes[off_q]};
            WIDTH_HALF: lane = {48'b0, rword.halves[off_q[2:1]]};
            WIDTH_WORD: lane = {32'b0, rword.words[off_q[2]]};
            default:    lane = rword.raw;
        endcase
    end

    // faulting load returns zero
    assign rdata      = fault_q ? '0 : lane;
    assign load_fault = fault_q;

endmodule

/* verilog/data_mem_top.sv */
// data memory top: byte-addressed RAM window with load and store paths
`timescale 1ns/1ps

module data_mem_top #(
    parameter logic [63:0] MEM_BASE = 64'h0000_0000_8000_0000,
    parameter int          IDX_W    = 10
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [63:0] raddr,
    input  logic        ren,
    input  logic [63:0] waddr,
    input  logic [63:0] wdata,
    input  logic        wen,
    input  logic [1:0]  width,
    output logic [63:0] rdata,
    output logic        load_fault,
    output logic        store_fault
);
    import mem_pkg::*;

    logic [IDX_W-1:0] ridx;
    logic [IDX_W-1:0] widx;
    logic             rfault;
    logic             wfault;
    dword_u           rword;

    mem_wr_if #(.IDX_W(IDX_W)) wr_bus ();

    // faults for both paths come from here only
    mem_addr_check #(
        .MEM_BASE (MEM_BASE),
        .IDX_W    (IDX_W)
    ) u_addr_check (
        .raddr  (raddr),
        .waddr  (waddr),
        .width  (mem_width_e'(width)),
        .ridx   (ridx),
        .rfault (rfault),
        .widx   (widx),
        .wfault (wfault)
    );

    mem_store_merge #(
        .IDX_W (IDX_W)
    ) u_store_merge (
        .waddr_lo (waddr[2:0]),
        .wdata    (wdata),
        .width    (mem_width_e'(width)),
        .widx     (widx),
        .wfault   (wfault),
        .wen      (wen),
        .wr       (wr_bus.source)
    );

    mem_dword_ram #(
        .IDX_W (IDX_W)
    ) u_dword_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr_bus.sink),
        .ridx   (ridx),
        .ren    (ren),
        .rword  (rword)
    );

    mem_load_extract u_load_extract (
        .clk         (clk),
        .arst_n      (arst_n),
        .ren         (ren),
        .raddr_lo    (raddr[2:0]),
        .width       (mem_width_e'(width)),
        .rfault      (rfault),
        .wen         (wen),
        .wfault      (wfault),
        .rword       (rword),
        .rdata       (rdata),
        .load_fault  (load_fault),
        .store_fault (store_fault)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// testbench clock and reset source: free-running clock, reset held for a fixed cycle count
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* testbench/tb_data_mem.sv */
// data memory testbench: byte-level model, directed and random accesses, result line
`timescale 1ns/1ps

module tb_data_mem;

    localparam logic [63:0] MEM_BASE      = 64'h0000_0000_8000_0000;
    localparam int          IDX_W         = 6;
    localparam int          WIN_BYTES     = (2 ** IDX_W) * 8;
    localparam int          RESET_TIMEOUT = 100;

    logic        clk;
    logic        arst_n;
    logic [63:0] raddr;
    logic        ren;
    logic [63:0] waddr;
    logic [63:0] wdata;
    logic        wen;
    logic [1:0]  width;
    logic [63:0] rdata;
    logic        load_fault;
    logic        store_fault;

    logic [7:0]  model [WIN_BYTES];
    integer      seed;
    int          errors;
    int          loads;
    int          stores;
    string       test_name;

    // expectations travel with the inputs, then hold once the DUT has sampled them
    logic        pend_load;
    logic [63:0] pend_rdata;
    logic        pend_lfault;
    logic        pend_sfault;
    logic [63:0] exp_rdata;
    logic        exp_lfault;
    logic        exp_sfault;

    tb_clock_gen #(.PERIOD_NS(10.0), .RESET_CYCLES(16)) clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    data_mem_top #(.MEM_BASE(MEM_BASE), .IDX_W(IDX_W)) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .raddr       (raddr),
        .ren         (ren),
        .waddr       (waddr),
        .wdata       (wdata),
        .wen         (wen),
        .width       (width),
        .rdata       (rdata),
        .load_fault  (load_fault),
        .store_fault (store_fault)
    );

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_rdata  <= '0;
            exp_lfault <= 1'b0;
            exp_sfault <= 1'b0;
        end else begin
            if (pend_load) begin
                exp_rdata  <= pend_rdata;
                exp_lfault <= pend_lfault;
            end
            exp_sfault <= pend_sfault;
        end
    end

    rdata_check: assert property (@(posedge clk) disable iff (!arst_n) rdata == exp_rdata)
        else begin
            errors++;
            $display("error %s: rdata expected %h actual %h",
                     test_name, $sampled(exp_rdata), $sampled(rdata));
        end

    load_fault_check: assert property (@(posedge clk) disable iff (!arst_n)
                                       load_fault == exp_lfault)
        else begin
            errors++;
            $display("error %s: load_fault expected %b actual %b",
                     test_name, $sampled(exp_lfault), $sampled(load_fault));
        end

    store_fault_check: assert property (@(posedge clk) disable iff (!arst_n)
                                        store_fault == exp_sfault)
        else begin
            errors++;
            $display("error %s: store_fault expected %b actual %b",
                     test_name, $sampled(exp_sfault), $sampled(store_fault));
        end

    function automatic int size_of(input logic [1:0] w);
        return 1 << w;
    endfunction

    // outside the window, or low bits not a multiple of the size
    function automatic logic access_fault(input logic [63:0] a, input logic [1:0] w);
        logic outside;
        logic odd;
        outside = (a < MEM_BASE) || (a >= MEM_BASE + WIN_BYTES);
        odd     = (a[2:0] & 3'(size_of(w) - 1)) != 3'd0;
        return outside || odd;
    endfunction

    function automatic logic [63:0] model_load(input logic [63:0] a, input logic [1:0] w);
        logic [63:0] v;
        int          off;
        v   = '0;
        off = int'(a - MEM_BASE);
        for (int i = 0; i < size_of(w); i++) begin
            v[8*i +: 8] = model[off + i];
        end
        return v;
    endfunction

    function automatic void model_store(input logic [63:0] a, input logic [63:0] d,
                                        input logic [1:0] w);
        int off;
        off = int'(a - MEM_BASE);
        for (int i = 0; i < size_of(w); i++) begin
            model[off + i] = d[8*i +: 8];
        end
    endfunction

    // one cycle of stimulus on both paths, sharing the width code
    task automatic issue_access(input logic rd, input logic [63:0] ra, input logic wr,
                                input logic [63:0] wa, input logic [63:0] wd,
                                input logic [1:0] w);
        logic        lf;
        logic        sf;
        logic [63:0] ld;
        lf = access_fault(ra, w);
        sf = access_fault(wa, w);
        ld = '0;
        if (rd && !lf) begin
            ld = model_load(ra, w);
        end
        @(posedge clk);
        ren         <= rd;
        raddr       <= ra;
        wen         <= wr;
        waddr       <= wa;
        wdata       <= wd;
        width       <= w;
        pend_load   <= rd;
        pend_rdata  <= ld;
        pend_lfault <= lf;
        pend_sfault <= wr && sf;
        // read before write, so the model changes after the load lookup
        if (wr && !sf) begin
            model_store(wa, wd, w);
        end
        loads  += int'(rd);
        stores += int'(wr);
    endtask

    task automatic load_at(input logic [63:0] a, input logic [1:0] w);
        issue_access(1'b1, a, 1'b0, '0, '0, w);
    endtask

    task automatic store_at(input logic [63:0] a, input logic [63:0] d, input logic [1:0] w);
        issue_access(1'b0, '0, 1'b1, a, d, w);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            ren         <= 1'b0;
            wen         <= 1'b0;
            pend_load   <= 1'b0;
            pend_sfault <= 1'b0;
        end
    endtask

    initial begin
        int          cnt;
        logic [31:0] rnd;
        logic [1:0]  w;
        logic [63:0] a;
        logic [63:0] d;
        seed        = 32'hc92a07f6;
        errors      = 0;
        loads       = 0;
        stores      = 0;
        test_name   = "reset";
        ren         = 1'b0;
        wen         = 1'b0;
        raddr       = '0;
        waddr       = '0;
        wdata       = '0;
        width       = 2'd0;
        pend_load   = 1'b0;
        pend_rdata  = '0;
        pend_lfault = 1'b0;
        pend_sfault = 1'b0;

        cnt = 0;
        while (arst_n !== 1'b1 && cnt < RESET_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("Result: FAILED");
            $finish;
        end
        idle_cycles(4);

        test_name = "store_then_load";
        for (int i = 0; i < WIN_BYTES / 8; i++) begin
            d[31:0]  = $random(seed);
            d[63:32] = $random(seed);
            store_at(MEM_BASE + 64'(8 * i), d, 2'd3);
        end
        for (int i = 0; i < 40; i++) begin
            rnd      = $random(seed);
            w        = rnd[1:0];
            a        = MEM_BASE + 64'(rnd[31:8] % WIN_BYTES);
            a        = a & ~64'(size_of(w) - 1);
            d[31:0]  = $random(seed);
            d[63:32] = $random(seed);
            store_at(a, d, w);
        end
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 12; i++) begin
                rnd = $random(seed);
                a   = MEM_BASE + 64'(rnd % WIN_BYTES);
                load_at(a & ~64'(size_of(2'(k)) - 1), 2'(k));
            end
        end
        idle_cycles(3);

        test_name = "lane_isolation";
        store_at(MEM_BASE + 64'h40, 64'h0123_4567_89ab_cdef, 2'd3);
        store_at(MEM_BASE + 64'h43, 64'hffff_ffff_ffff_ffa5, 2'd0);
        store_at(MEM_BASE + 64'h46, 64'hffff_ffff_ffff_5ac3, 2'd1);
        store_at(MEM_BASE + 64'h48, 64'h0000_0000_dead_beef, 2'd2);
        load_at(MEM_BASE + 64'h40, 2'd3);
        load_at(MEM_BASE + 64'h48, 2'd3);
        idle_cycles(3);

        test_name = "misalignment";
        store_at(MEM_BASE + 64'h81, 64'h1111_2222_3333_4444, 2'd1);
        idle_cycles(2);
        store_at(MEM_BASE + 64'h82, 64'h5555_6666_7777_8888, 2'd2);
        store_at(MEM_BASE + 64'h84, 64'h9999_aaaa_bbbb_cccc, 2'd3);
        load_at(MEM_BASE + 64'h80, 2'd3);
        load_at(MEM_BASE + 64'h83, 2'd1);
        load_at(MEM_BASE + 64'h86, 2'd2);
        load_at(MEM_BASE + 64'h8c, 2'd3);
        idle_cycles(2);
        load_at(MEM_BASE + 64'h80, 2'd3);
        idle_cycles(3);

        test_name = "out_of_window";
        store_at(MEM_BASE - 64'd8, 64'hbad0_bad0_bad0_bad0, 2'd3);
        store_at(MEM_BASE + 64'(WIN_BYTES), 64'hbad1_bad1_bad1_bad1, 2'd3);
        store_at(MEM_BASE - 64'd1, 64'h0000_0000_0000_00ee, 2'd0);
        load_at(MEM_BASE - 64'd8, 2'd3);
        load_at(MEM_BASE + 64'(WIN_BYTES), 2'd3);
        load_at(MEM_BASE + 64'(WIN_BYTES) + 64'd4, 2'd2);
        load_at(MEM_BASE, 2'd3);
        load_at(MEM_BASE + 64'(WIN_BYTES - 8), 2'd3);
        idle_cycles(3);

        test_name = "read_before_write";
        issue_access(1'b1, MEM_BASE + 64'h100, 1'b1, MEM_BASE + 64'h100,
                     64'hfeed_face_cafe_f00d, 2'd3);
        load_at(MEM_BASE + 64'h100, 2'd3);
        issue_access(1'b1, MEM_BASE + 64'h10c, 1'b1, MEM_BASE + 64'h10c,
                     64'h0000_0000_1357_9bdf, 2'd2);
        load_at(MEM_BASE + 64'h108, 2'd3);
        idle_cycles(4);

        $display("errors=%0d loads=%0d stores=%0d", errors, loads, stores);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* data_mem.f */
verilog/mem_pkg.sv
verilog/mem_wr_if.sv
verilog/mem_addr_check.sv
verilog/mem_store_merge.sv
verilog/mem_dword_ram.sv
verilog/mem_load_extract.sv
verilog/data_mem_top.sv
testbench/tb_clock_gen.sv
testbench/tb_data_mem.sv
